// File: hdl/ttc_lite_pkg.sv
// ttc lite package: shared widths, register map and control/event structs
package ttc_lite_pkg;

  // ------------------------------
  // widths
  // ------------------------------

  // counter, interval and match values
  typedef logic [15:0] count_t;

  // clock control register
  // bit 0 prescale enable, bits 4:1 prescale value n, bits 6:5 stored only
  typedef logic [6:0] clk_ctrl_t;

  // word address, paddr[4:2]
  typedef logic [2:0] reg_addr_t;

  // apb data bus
  typedef logic [15:0] bus_data_t;

  // ------------------------------
  // register fields
  // ------------------------------

  // counter control register, bit 0 is cnt_disable
  typedef struct packed {
    logic restart;        // level, acted on at rising edge
    logic match_en;       // enables match event
    logic interval_mode;  // wrap at interval instead of all ones
    logic cnt_disable;    // stops counting
  } ttc_ctrl_t;

  // one-cycle event strobes, bit 0 is interval
  typedef struct packed {
    logic overflow;
    logic match;
    logic interval;
  } ttc_evt_t;

  // ------------------------------
  // register map
  // ------------------------------
  localparam reg_addr_t ADDR_CLK_CTRL   = 3'd0;
  localparam reg_addr_t ADDR_CNTR_CTRL  = 3'd1;
  localparam reg_addr_t ADDR_COUNT      = 3'd2;
  localparam reg_addr_t ADDR_INTERVAL   = 3'd3;
  localparam reg_addr_t ADDR_MATCH      = 3'd4;
  localparam reg_addr_t ADDR_INT_STATUS = 3'd5;
  localparam reg_addr_t ADDR_INT_ENABLE = 3'd6;

endpackage

// File: hdl/ttc_reg_decode.sv
// ttc register decode: apb writes to control registers and the read mux
`timescale 1ns/1ps

module ttc_reg_decode (
  input  logic                   pclk24,
  input  logic                   n_p_reset24,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  ttc_lite_pkg::reg_addr_t paddr,
  input  ttc_lite_pkg::bus_data_t pwdata,
  input  ttc_lite_pkg::clk_ctrl_t clk_ctrl,
  input  ttc_lite_pkg::count_t    count,
  input  logic [2:0]             status,
  output ttc_lite_pkg::bus_data_t prdata,
  output logic                   clk_ctrl_sel,
  output ttc_lite_pkg::ttc_ctrl_t ctrl,
  output ttc_lite_pkg::count_t    interval,
  output ttc_lite_pkg::count_t    match,
  output logic [2:0]             int_enable,
  output logic                   status_rd
);

  import ttc_lite_pkg::*;

  logic wr_en;
  logic rd_en;

  // access phase write, setup phase read
  assign wr_en = psel & penable & pwrite;
  assign rd_en = psel & ~pwrite;

  // clock control lives in the counter reset block
  assign clk_ctrl_sel = wr_en & (paddr == ADDR_CLK_CTRL);

  // status clears on the access phase of its read
  assign status_rd = psel & penable & ~pwrite & (paddr == ADDR_INT_STATUS);

  // ------------------------------
  // write side
  // ------------------------------
  always_ff @(posedge pclk24 or negedge n_p_reset24)
  begin
    if (!n_p_reset24)
    begin
      ctrl       <= '0;
      interval   <= '0;
      match      <= '0;
      int_enable <= '0;
    end
    else if (wr_en)
    begin
      case (paddr)
        ADDR_CNTR_CTRL:  ctrl       <= ttc_ctrl_t'(pwdata[3:0]);
        ADDR_INTERVAL:   interval   <= count_t'(pwdata);
        ADDR_MATCH:      match      <= count_t'(pwdata);
        ADDR_INT_ENABLE: int_enable <= pwdata[2:0];
        default:         ;
      endcase
    end
  end

  // ------------------------------
  // read mux
  // ------------------------------
  always_comb
  begin
    prdata = '0;
    if (rd_en)
    begin
      case (paddr)
        ADDR_CLK_CTRL:   prdata = bus_data_t'(clk_ctrl);
        ADDR_CNTR_CTRL:  prdata = bus_data_t'(ctrl);
        ADDR_COUNT:      prdata = bus_data_t'(count);
        ADDR_INTERVAL:   prdata = bus_data_t'(interval);
        ADDR_MATCH:      prdata = bus_data_t'(match);
        ADDR_INT_STATUS: prdata = bus_data_t'(status);
        ADDR_INT_ENABLE: prdata = bus_data_t'(int_enable);
        default:         prdata = '0;
      endcase
    end
  end

endmodule

// File: hdl/ttc_count_rst_lite.sv
// ttc counter reset block: clock control register and restart enable drop
`timescale 1ns/1ps

module ttc_count_rst_lite (
  input  logic                   pclk24,
  input  logic                   n_p_reset24,
  input  ttc_lite_pkg::clk_ctrl_t pwdata,
  input  logic                   clk_ctrl_sel,
  input  logic                   restart,
  output logic                   count_en,
  output ttc_lite_pkg::clk_ctrl_t clk_ctrl
);

  // set on the first restart cycle, held until restart drops
  logic restart_seen;

  // ------------------------------
  // restart edge tracking
  // ------------------------------
  // count_en comes up one cycle after reset release
  always_ff @(posedge pclk24 or negedge n_p_reset24)
  begin
    if (!n_p_reset24)
    begin
      restart_seen <= 1'b0;
      count_en     <= 1'b0;
    end
    else if (restart & ~restart_seen)
    begin
      // new restart, drop enable for one cycle
      restart_seen <= 1'b1;
      count_en     <= 1'b0;
    end
    else
    begin
      // held restart does nothing more
      if (!restart)
      begin
        restart_seen <= 1'b0;
      end
      count_en <= 1'b1;
    end
  end

  // ------------------------------
  // clock control register
  // ------------------------------
  always_ff @(posedge pclk24 or negedge n_p_reset24)
  begin
    if (!n_p_reset24)
    begin
      clk_ctrl <= '0;
    end
    else if (clk_ctrl_sel)
    begin
      clk_ctrl <= pwdata;
    end
  end

endmodule

// File: hdl/ttc_prescaler.sv
// ttc prescaler: divides enabled cycles by 2^(n+1) into count ticks
`timescale 1ns/1ps

module ttc_prescaler (
  input  logic                   pclk24,
  input  logic                   n_p_reset24,
  input  logic                   count_en,
  input  ttc_lite_pkg::clk_ctrl_t clk_ctrl,
  input  ttc_lite_pkg::ttc_ctrl_t ctrl,
  output logic                   tick
);

  logic        ps_en;
  logic [3:0]  ps_val;
  logic        run;
  logic [15:0] div_cnt;
  logic [15:0] div_last;
  logic        div_term;

  // field split of clock control
  assign ps_en  = clk_ctrl[0];
  assign ps_val = clk_ctrl[4:1];

  // enabled cycle, not restarting and not stopped
  assign run = count_en & ~ctrl.cnt_disable;

  // terminal count is divisor - 1, n = 15 gives all ones
  assign div_last = 16'((17'd1 << (ps_val + 5'd1)) - 17'd1);
  assign div_term = (div_cnt == div_last);

  // ------------------------------
  // tick output
  // ------------------------------
  // bypass passes run straight through
  assign tick = ps_en ? (run & div_term) : run;

  // ------------------------------
  // divider
  // ------------------------------
  always_ff @(posedge pclk24 or negedge n_p_reset24)
  begin
    if (!n_p_reset24)
    begin
      div_cnt <= '0;
    end
    else if (!count_en)
    begin
      // restart clears the divider
      div_cnt <= '0;
    end
    else if (!ps_en)
    begin
      div_cnt <= '0;
    end
    else if (run)
    begin
      if (div_term)
      begin
        div_cnt <= '0;
      end
      else
      begin
        div_cnt <= div_cnt + 16'd1;
      end
    end
    // disable holds the divider where it is
  end

endmodule

// File: hdl/ttc_counter.sv
// ttc counter: 16-bit up counter with interval/overflow wrap and match compare
`timescale 1ns/1ps

module ttc_counter (
  input  logic                   pclk24,
  input  logic                   n_p_reset24,
  input  logic                   count_en,
  input  logic                   tick,
  input  ttc_lite_pkg::ttc_ctrl_t ctrl,
  input  ttc_lite_pkg::count_t    interval,
  input  ttc_lite_pkg::count_t    match,
  output ttc_lite_pkg::count_t    count,
  output ttc_lite_pkg::ttc_evt_t  evt
);

  logic at_interval;
  logic at_max;
  logic match_eq;
  logic match_eq_q;

  // wrap conditions
  assign at_interval = ctrl.interval_mode & (count == interval);
  assign at_max      = (count == '1);

  // compare on the current count
  assign match_eq = (count == match);

  // ------------------------------
  // count register
  // ------------------------------
  always_ff @(posedge pclk24 or negedge n_p_reset24)
  begin
    if (!n_p_reset24)
    begin
      count <= '0;
    end
    else if (!count_en)
    begin
      // restart or post-reset cycle
      count <= '0;
    end
    else if (tick)
    begin
      if (at_interval || (!ctrl.interval_mode && at_max))
      begin
        count <= '0;
      end
      else
      begin
        count <= count + 1'b1;
      end
    end
  end

  // ------------------------------
  // event strobes
  // ------------------------------
  // one cycle behind the count value they report
  always_ff @(posedge pclk24 or negedge n_p_reset24)
  begin
    if (!n_p_reset24)
    begin
      evt        <= '0;
      match_eq_q <= 1'b0;
    end
    else
    begin
      // interval wrap on this tick
      evt.interval <= count_en & tick & at_interval;
      // all-ones wrap, interval mode off
      evt.overflow <= count_en & tick & ~ctrl.interval_mode & at_max;
      // first cycle of equality only, slow ticks hold the count
      evt.match    <= ctrl.match_en & match_eq & ~match_eq_q;
      match_eq_q   <= match_eq;
    end
  end

endmodule

// File: hdl/ttc_interrupt.sv
// ttc interrupt stage: sticky event status, clear on read, masked irq
`timescale 1ns/1ps

module ttc_interrupt (
  input  logic                  pclk24,
  input  logic                  n_p_reset24,
  input  ttc_lite_pkg::ttc_evt_t evt,
  input  logic                  status_rd,
  input  logic [2:0]            int_enable,
  output logic [2:0]            status,
  output logic                  irq
);

  logic [2:0] evt_bits;
  logic [2:0] keep_mask;

  // bit 0 interval, bit 1 match, bit 2 overflow
  assign evt_bits = evt;

  // a status read clears every bit
  assign keep_mask = status_rd ? 3'b000 : 3'b111;

  // ------------------------------
  // sticky status
  // ------------------------------
  always_ff @(posedge pclk24 or negedge n_p_reset24)
  begin
    if (!n_p_reset24)
    begin
      status <= '0;
    end
    else
    begin
      // set wins over a clear in the same cycle
      status <= (status & keep_mask) | evt_bits;
    end
  end

  // masked interrupt, straight from status
  assign irq = |(status & int_enable);

endmodule

// File: hdl/ttc_timer_lite.sv
// ttc lite timer top: register decode, restart, prescale, count and interrupt
`timescale 1ns/1ps

module ttc_timer_lite (
  input  logic                   pclk24,
  input  logic                   n_p_reset24,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  ttc_lite_pkg::reg_addr_t paddr,
  input  ttc_lite_pkg::bus_data_t pwdata,
  output ttc_lite_pkg::bus_data_t prdata,
  output logic                   irq
);

  import ttc_lite_pkg::*;

  // ------------------------------
  // stage interconnect
  // ------------------------------
  logic       clk_ctrl_sel;
  clk_ctrl_t  clk_ctrl;
  ttc_ctrl_t  ctrl;
  count_t     interval;
  count_t     match;
  logic [2:0] int_enable;
  logic       status_rd;
  logic       count_en;
  logic       tick;
  count_t     count;
  ttc_evt_t   evt;
  logic [2:0] status;

  // bus side registers and read mux
  ttc_reg_decode i_ttc_reg_decode (
    .pclk24       (pclk24),
    .n_p_reset24  (n_p_reset24),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .clk_ctrl     (clk_ctrl),
    .count        (count),
    .status       (status),
    .prdata       (prdata),
    .clk_ctrl_sel (clk_ctrl_sel),
    .ctrl         (ctrl),
    .interval     (interval),
    .match        (match),
    .int_enable   (int_enable),
    .status_rd    (status_rd)
  );

  // clock control takes the low data bits
  ttc_count_rst_lite i_ttc_count_rst_lite (
    .pclk24       (pclk24),
    .n_p_reset24  (n_p_reset24),
    .pwdata       (clk_ctrl_t'(pwdata[6:0])),
    .clk_ctrl_sel (clk_ctrl_sel),
    .restart      (ctrl.restart),
    .count_en     (count_en),
    .clk_ctrl     (clk_ctrl)
  );

  ttc_prescaler i_ttc_prescaler (
    .pclk24      (pclk24),
    .n_p_reset24 (n_p_reset24),
    .count_en    (count_en),
    .clk_ctrl    (clk_ctrl),
    .ctrl        (ctrl),
    .tick        (tick)
  );

  ttc_counter i_ttc_counter (
    .pclk24      (pclk24),
    .n_p_reset24 (n_p_reset24),
    .count_en    (count_en),
    .tick        (tick),
    .ctrl        (ctrl),
    .interval    (interval),
    .match       (match),
    .count       (count),
    .evt         (evt)
  );

  ttc_interrupt i_ttc_interrupt (
    .pclk24      (pclk24),
    .n_p_reset24 (n_p_reset24),
    .evt         (evt),
    .status_rd   (status_rd),
    .int_enable  (int_enable),
    .status      (status),
    .irq         (irq)
  );

endmodule

// File: tests/tb_clk_gen.sv
// testbench clock and reset generator, 8 ns period, reset held 3 cycles
`timescale 1ns/1ps

module tb_clk_gen (
  output logic pclk24,
  output logic n_p_reset24
);

  initial
  begin
    pclk24      = 1'b0;
    n_p_reset24 = 1'b0;
    forever #4 pclk24 = ~pclk24;
  end

  // release on a falling edge, away from the active edge
  initial
  begin
    repeat (3) @(posedge pclk24);
    @(negedge pclk24);
    n_p_reset24 = 1'b1;
  end

endmodule

// File: tests/ttc_timer_lite_chk.sv
// ttc lite checker: concurrent assertions on restart, irq and interval wrap
`timescale 1ns/1ps

module ttc_timer_lite_chk (
  input logic                   pclk24,
  input logic                   n_p_reset24,
  input ttc_lite_pkg::ttc_ctrl_t ctrl,
  input logic                   count_en,
  input logic                   irq,
  input ttc_lite_pkg::ttc_evt_t  evt,
  input logic [2:0]             int_enable,
  input ttc_lite_pkg::count_t    count,
  input ttc_lite_pkg::count_t    interval
);

  // count of assertion failures
  int unsigned fail_cnt = 0;

  // ------------------------------
  // restart drops enable once
  a_restart_drop: assert property (@(posedge pclk24) disable iff (!n_p_reset24)
    $rose(ctrl.restart) |=> !count_en ##1 count_en)
  else
  begin
    fail_cnt++;
    $error("count_en not low for exactly one cycle after restart");
  end

  // enabled event reaches irq through sticky status
  a_irq_event: assert property (@(posedge pclk24) disable iff (!n_p_reset24)
    ((evt & int_enable) != 3'b000) |=> irq)
  else
  begin
    fail_cnt++;
    $error("irq not raised after an enabled event");
  end

  // interval wrap keeps count in range
  a_interval_max: assert property (@(posedge pclk24) disable iff (!n_p_reset24)
    ctrl.interval_mode |-> count <= interval)
  else
  begin
    fail_cnt++;
    $error("count above interval in interval mode");
  end

endmodule

bind ttc_timer_lite ttc_timer_lite_chk i_ttc_timer_lite_chk (
  .pclk24      (pclk24),
  .n_p_reset24 (n_p_reset24),
  .ctrl        (ctrl),
  .count_en    (count_en),
  .irq         (irq),
  .evt         (evt),
  .int_enable  (int_enable),
  .count       (count),
  .interval    (interval)
);

// File: tests/ttc_timer_lite_tb.sv
// ttc lite testbench: table of bus accesses checked against a tick model
`timescale 1ns/1ps

module ttc_timer_lite_tb;

  import ttc_lite_pkg::*;

  // row kinds
  localparam logic [2:0] OP_WR   = 3'd0;
  localparam logic [2:0] OP_RD   = 3'd1;
  localparam logic [2:0] OP_RDC  = 3'd2;
  localparam logic [2:0] OP_RDLE = 3'd3;
  localparam logic [2:0] OP_IRQ  = 3'd4;
  localparam logic [2:0] OP_WAIT = 3'd5;

  typedef struct packed {
    logic [2:0]  op;
    reg_addr_t   addr;
    logic [15:0] data;   // write data or expected value
    logic [31:0] n;      // wait cycles
  } row_t;

  logic      pclk24;
  logic      n_p_reset24;
  logic      psel;
  logic      penable;
  logic      pwrite;
  reg_addr_t paddr;
  bus_data_t pwdata;
  bus_data_t prdata;
  logic      irq;

  row_t        rows[$];
  int unsigned limit;
  int unsigned cycles;
  int unsigned errors;

  // tick model state
  int unsigned en_cycles;
  int unsigned age;
  logic        dis_m;
  logic        restart_m;
  logic        ps_en_m;
  logic [3:0]  ps_n_m;

  tb_clk_gen i_tb_clk_gen (.pclk24(pclk24), .n_p_reset24(n_p_reset24));

  ttc_timer_lite i_ttc_timer_lite (
    .pclk24(pclk24), .n_p_reset24(n_p_reset24), .psel(psel), .penable(penable),
    .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .irq(irq)
  );

  // count = enabled cycles since restart over the divisor
  function automatic count_t expected_count();
    int unsigned divisor;
    divisor = ps_en_m ? (32'd1 << (ps_n_m + 1)) : 32'd1;
    return count_t'(en_cycles / divisor);
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
      $display("Test FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic add_row(logic [2:0] op, reg_addr_t addr, logic [15:0] data, int n);
    rows.push_back('{op, addr, data, n});
  endtask

  // restart needs a low level first
  task automatic add_restart();
    add_row(OP_WR, ADDR_CNTR_CTRL, 16'h0, 0);
    add_row(OP_WR, ADDR_CNTR_CTRL, 16'h8, 0);
  endtask

  // one clock edge, model updated with pre-edge state
  task automatic next_cycle();
    if (age == 1)
      en_cycles = 0;
    else if (!dis_m)
      en_cycles++;
    if (age < 2)
      age++;
    @(negedge pclk24);
  endtask

  task automatic track_write(reg_addr_t addr, logic [15:0] data);
    if (addr == ADDR_CNTR_CTRL)
    begin
      if (data[3] && !restart_m)
        age = 0;
      restart_m = data[3];
      dis_m     = data[0];
    end
    if (addr == ADDR_CLK_CTRL)
    begin
      ps_en_m = data[0];
      ps_n_m  = data[4:1];
    end
  endtask

  task automatic build_rows();
    count_t ival;
    count_t mval;
    // ------------------------------
    // reset values
    for (int a = 0; a < 7; a++)
      add_row((a == 2) ? OP_RDC : OP_RD, reg_addr_t'(a), 16'h0, 0);
    add_row(OP_IRQ, 0, 16'h0, 0);
    // readback
    add_row(OP_WR, ADDR_CLK_CTRL, 16'h7f, 0);
    add_row(OP_RD, ADDR_CLK_CTRL, 16'h7f, 0);
    add_row(OP_WR, ADDR_CNTR_CTRL, 16'h9, 0);
    add_row(OP_RD, ADDR_CNTR_CTRL, 16'h9, 0);
    ival = count_t'($urandom);
    add_row(OP_WR, ADDR_INTERVAL, ival, 0);
    add_row(OP_RD, ADDR_INTERVAL, ival, 0);
    add_row(OP_WR, ADDR_MATCH, ~ival, 0);
    add_row(OP_RD, ADDR_MATCH, ~ival, 0);
    add_row(OP_WR, ADDR_INT_ENABLE, 16'h5, 0);
    add_row(OP_RD, ADDR_INT_ENABLE, 16'h5, 0);
    add_row(OP_WR, ADDR_INT_ENABLE, 16'h0, 0);
    add_row(OP_WR, ADDR_CLK_CTRL, 16'h0, 0);
    // ------------------------------
    // restart, held restart, second restart
    add_restart();
    add_row(OP_WAIT, 0, 0, 20);
    add_row(OP_RDC, ADDR_COUNT, 0, 0);
    add_row(OP_WR, ADDR_CNTR_CTRL, 16'h8, 0);
    add_row(OP_WAIT, 0, 0, 5);
    add_row(OP_RDC, ADDR_COUNT, 0, 0);
    add_restart();
    add_row(OP_WAIT, 0, 0, 3);
    add_row(OP_RDC, ADDR_COUNT, 0, 0);
    // prescale, then frozen by disable
    for (int n = 0; n < 4; n += 1 + n)
    begin
      add_row(OP_WR, ADDR_CLK_CTRL, 16'((n << 1) | 1), 0);
      add_restart();
      add_row(OP_WAIT, 0, 0, 37 + 11 * n);
      add_row(OP_RDC, ADDR_COUNT, 0, 0);
      add_row(OP_WR, ADDR_CNTR_CTRL, 16'h9, 0);
      add_row(OP_WAIT, 0, 0, 10);
      add_row(OP_RDC, ADDR_COUNT, 0, 0);
    end
    // ------------------------------
    // interval wrap and irq
    add_row(OP_WR, ADDR_CLK_CTRL, 16'h0, 0);
    ival = count_t'($urandom_range(40, 8));
    add_row(OP_WR, ADDR_INTERVAL, ival, 0);
    add_row(OP_WR, ADDR_INT_ENABLE, 16'h1, 0);
    add_restart();
    add_row(OP_WR, ADDR_CNTR_CTRL, 16'ha, 0);
    add_row(OP_WAIT, 0, 0, ival + 10);
    add_row(OP_RDLE, ADDR_COUNT, ival, 0);
    add_row(OP_IRQ, 0, 16'h1, 0);
    add_row(OP_WR, ADDR_CNTR_CTRL, 16'hb, 0);
    add_row(OP_WAIT, 0, 0, 3);
    add_row(OP_RD, ADDR_INT_STATUS, 16'h1, 0);
    add_row(OP_RD, ADDR_INT_STATUS, 16'h0, 0);
    add_row(OP_IRQ, 0, 16'h0, 0);
    // match, masked
    mval = count_t'($urandom_range(200, 20));
    add_row(OP_WR, ADDR_MATCH, mval, 0);
    add_restart();
    add_row(OP_WR, ADDR_CNTR_CTRL, 16'hc, 0);
    add_row(OP_WAIT, 0, 0, mval + 8);
    add_row(OP_IRQ, 0, 16'h0, 0);
    add_row(OP_RD, ADDR_INT_STATUS, 16'h2, 0);
    // overflow after a full 16-bit lap
    add_row(OP_WR, ADDR_INT_ENABLE, 16'h4, 0);
    add_restart();
    add_row(OP_WAIT, 0, 0, 65545);
    add_row(OP_IRQ, 0, 16'h1, 0);
    add_row(OP_RD, ADDR_INT_STATUS, 16'h4, 0);
    add_row(OP_RD, ADDR_INT_STATUS, 16'h0, 0);
  endtask

  // ------------------------------
  // timeout
  always @(posedge pclk24)
  begin
    cycles++;
    if (cycles > limit)
    begin
      $display("run stopped after %0d cycles without finishing the table", limit);
      $display("Test FAILED");
      $fatal(1, "timeout");
    end
  end

  // ------------------------------
  // bound assertion failures
  always @(negedge pclk24)
  begin
    if (i_ttc_timer_lite.i_ttc_timer_lite_chk.fail_cnt != 0)
    begin
      $display("a bound assertion on the timer failed");
      $display("Test FAILED");
      $fatal(1, "assertion failure");
    end
  end

  initial
  begin
    int unsigned total;
    row_t r;
    psel      = 0;
    penable   = 0;
    pwrite    = 0;
    paddr     = '0;
    pwdata    = '0;
    cycles    = 0;
    errors    = 0;
    total     = 0;
    en_cycles = 0;
    age       = 1;
    dis_m     = 0;
    restart_m = 0;
    ps_en_m   = 0;
    ps_n_m    = '0;
    void'($urandom(49331));
    build_rows();
    foreach (rows[i])
      total += rows[i].n + 1;
    limit = 2 * total + 200;
    @(posedge n_p_reset24);
    foreach (rows[i])
    begin
      r       = rows[i];
      psel    = 0;
      penable = 0;
      pwrite  = 0;
      paddr   = r.addr;
      pwdata  = r.data;
      case (r.op)
        OP_WR:
        begin
          psel    = 1;
          penable = 1;
          pwrite  = 1;
          next_cycle();
          track_write(r.addr, r.data);
        end
        OP_WAIT:
          repeat (r.n) next_cycle();
        default:
        begin
          psel = (r.op != OP_IRQ);
          penable = psel;
          #2;
          if (r.op == OP_RD)
            check_value($sformatf("prdata[%0d]", r.addr), prdata, r.data);
          else if (r.op == OP_RDC)
            check_value("count", prdata, expected_count());
          else if (r.op == OP_RDLE)
            check_value("count_le_interval", prdata <= r.data, 1);
          else
            check_value("irq", irq, r.data[0]);
          next_cycle();
        end
      endcase
    end
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// File: all.f
hdl/ttc_lite_pkg.sv
hdl/ttc_reg_decode.sv
hdl/ttc_count_rst_lite.sv
hdl/ttc_prescaler.sv
hdl/ttc_counter.sv
hdl/ttc_interrupt.sv
hdl/ttc_timer_lite.sv
tests/tb_clk_gen.sv
tests/ttc_timer_lite_chk.sv
tests/ttc_timer_lite_tb.sv
